// File: hdl/dpr_pkg.sv
package dpr_pkg;

  // Operand and result width shared by every block
  localparam int WORD_W = 8;

  typedef logic [WORD_W-1:0] word_t;

  // Operation select codes
  // Codes 11 to 31 are undefined and give a zero result
  typedef enum logic [4:0] {
    OP_ADD = 5'd0,
    OP_DEC = 5'd1,
    OP_DIV = 5'd2,
    OP_INC = 5'd3,
    OP_MOD = 5'd4,
    OP_MUL = 5'd5,
    OP_MUX = 5'd6,
    OP_REG = 5'd7,
    OP_SHL = 5'd8,
    OP_SHR = 5'd9,
    OP_SUB = 5'd10
  } op_code_e;

  // Operand pair fed to every unit
  typedef struct packed {
    word_t a;
    word_t b;
  } operands_t;

  // Unsigned compare of a against b, exactly one flag set
  typedef struct packed {
    logic lt;
    logic gt;
    logic eq;
  } cmp_flags_t;

  // One field per single-cycle operation
  typedef struct packed {
    word_t sum;
    word_t diff;
    word_t inc;
    word_t dec;
    word_t prod;
    word_t shl;
    word_t shr;
    word_t mux;
  } alu_results_t;

  typedef struct packed {
    word_t quot;
    word_t rem;
  } div_results_t;

endpackage

// File: hdl/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
  input  dpr_pkg::operands_t    operands_i,
  input  logic                  mux_sel_i,
  output dpr_pkg::alu_results_t results_o,
  output dpr_pkg::cmp_flags_t   cmp_o
);

  localparam int PROD_W = 2 * dpr_pkg::WORD_W;

  dpr_pkg::word_t a;
  dpr_pkg::word_t b;

  // Subtraction with borrow out, shared by sub and the comparator
  logic [dpr_pkg::WORD_W:0] diff_ext;

  // Full product before truncation
  logic [PROD_W-1:0] prod_full;

  // Shift amount in range of the word
  logic shift_ok;

  dpr_pkg::word_t shl_res;
  dpr_pkg::word_t shr_res;

  assign a = operands_i.a;
  assign b = operands_i.b;

  // Adder and subtractor
  assign diff_ext = {1'b0, a} - {1'b0, b};

  always_comb begin
    results_o.sum  = a + b;
    results_o.diff = diff_ext[dpr_pkg::WORD_W-1:0];
  end

  // Increment and decrement wrap modulo 2^WORD_W
  always_comb begin
    results_o.inc = a + dpr_pkg::word_t'(1);
    results_o.dec = a - dpr_pkg::word_t'(1);
  end

  // Multiplier keeps only the low word
  assign prod_full = {{dpr_pkg::WORD_W{1'b0}}, a} * {{dpr_pkg::WORD_W{1'b0}}, b};

  always_comb begin
    results_o.prod = prod_full[dpr_pkg::WORD_W-1:0];
  end

  // Shifters
  // Amounts of WORD_W or more clear the word
  assign shift_ok = (b < dpr_pkg::word_t'(dpr_pkg::WORD_W));

  always_comb begin
    if (shift_ok) begin
      shl_res = a << b;
      shr_res = a >> b;
    end else begin
      shl_res = '0;
      shr_res = '0;
    end
  end

  always_comb begin
    results_o.shl = shl_res;
    results_o.shr = shr_res;
  end

  // Two-input mux
  always_comb begin
    if (mux_sel_i) begin
      results_o.mux = b;
    end else begin
      results_o.mux = a;
    end
  end

  // Comparator
  // Borrow out of the subtractor means a is below b
  always_comb begin
    cmp_o.eq = (diff_ext[dpr_pkg::WORD_W-1:0] == '0);
    cmp_o.lt = diff_ext[dpr_pkg::WORD_W];
    cmp_o.gt = !diff_ext[dpr_pkg::WORD_W] && !cmp_o.eq;
  end

endmodule

// File: hdl/divide_unit.sv
`timescale 1ns/1ps

module divide_unit (
  input  dpr_pkg::operands_t    operands_i,
  output dpr_pkg::div_results_t results_o
);

  // Partial remainder with one guard bit for the trial subtract
  logic [dpr_pkg::WORD_W:0] rem_acc;
  logic [dpr_pkg::WORD_W:0] trial;

  dpr_pkg::word_t quot;

  // Restoring shift-subtract, one quotient bit per step from the MSB
  always_comb begin
    rem_acc = '0;
    trial   = '0;
    quot    = '0;
    for (int i = dpr_pkg::WORD_W - 1; i >= 0; i--) begin
      // Bring down the next dividend bit
      rem_acc = {rem_acc[dpr_pkg::WORD_W-1:0], operands_i.a[i]};
      trial   = rem_acc - {1'b0, operands_i.b};

      // Guard bit clear means the divisor fit
      if (!trial[dpr_pkg::WORD_W]) begin
        rem_acc = trial;
        quot[i] = 1'b1;
      end
    end
  end

  // With b of zero every trial fits, so the quotient fills with ones
  // and the remainder is left equal to a
  always_comb begin
    results_o.quot = quot;
    results_o.rem  = rem_acc[dpr_pkg::WORD_W-1:0];
  end

endmodule

// File: hdl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [4:0]            op_sel_i,
  input  logic                  decouple_i,
  input  dpr_pkg::operands_t    operands_i,
  input  dpr_pkg::alu_results_t alu_i,
  input  dpr_pkg::div_results_t div_i,
  input  dpr_pkg::cmp_flags_t   cmp_i,
  output dpr_pkg::word_t        result_o,
  output dpr_pkg::cmp_flags_t   cmp_o,
  output logic                  decouple_status_o
);

  // Operand a from the previous edge, used by OP_REG
  dpr_pkg::word_t reg_q;

  dpr_pkg::word_t result_next;
  dpr_pkg::word_t result_q;
  dpr_pkg::cmp_flags_t cmp_q;
  logic decouple_q;

  // Operation select
  always_comb begin
    case (op_sel_i)
      dpr_pkg::OP_ADD: result_next = alu_i.sum;
      dpr_pkg::OP_DEC: result_next = alu_i.dec;
      dpr_pkg::OP_DIV: result_next = div_i.quot;
      dpr_pkg::OP_INC: result_next = alu_i.inc;
      dpr_pkg::OP_MOD: result_next = div_i.rem;
      dpr_pkg::OP_MUL: result_next = alu_i.prod;
      dpr_pkg::OP_MUX: result_next = alu_i.mux;
      dpr_pkg::OP_REG: result_next = reg_q;
      dpr_pkg::OP_SHL: result_next = alu_i.shl;
      dpr_pkg::OP_SHR: result_next = alu_i.shr;
      dpr_pkg::OP_SUB: result_next = alu_i.diff;
      default:         result_next = '0;
    endcase
  end

  // REG operand store keeps sampling while decoupled
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_q <= '0;
    end else begin
      reg_q <= operands_i.a;
    end
  end

  // Output registers freeze while decoupled
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      result_q <= '0;
      cmp_q    <= '0;
    end else if (!decouple_i) begin
      result_q <= result_next;
      cmp_q    <= cmp_i;
    end
  end

  // Decouple status follows the request one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      decouple_q <= 1'b0;
    end else begin
      decouple_q <= decouple_i;
    end
  end

  assign result_o          = result_q;
  assign cmp_o             = cmp_q;
  assign decouple_status_o = decouple_q;

endmodule

// File: hdl/dpr_top.sv
`timescale 1ns/1ps

module dpr_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  dpr_pkg::word_t      a_i,
  input  dpr_pkg::word_t      b_i,
  input  logic [4:0]          op_sel_i,
  input  logic                mux_sel_i,
  input  logic                decouple_i,
  output dpr_pkg::word_t      result_o,
  output dpr_pkg::cmp_flags_t cmp_o,
  output logic                decouple_status_o
);

  dpr_pkg::operands_t    operands;
  dpr_pkg::alu_results_t alu_res;
  dpr_pkg::div_results_t div_res;
  dpr_pkg::cmp_flags_t   cmp_flags;

  // Operand pair shared by all units
  assign operands = '{a: a_i, b: b_i};

  // Single-cycle operations and comparator
  arith_unit u_arith (
    .operands_i (operands),
    .mux_sel_i  (mux_sel_i),
    .results_o  (alu_res),
    .cmp_o      (cmp_flags)
  );

  // Quotient and remainder from one divider
  divide_unit u_divide (
    .operands_i (operands),
    .results_o  (div_res)
  );

  // Select, register and decouple hold
  result_stage u_result (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .op_sel_i          (op_sel_i),
    .decouple_i        (decouple_i),
    .operands_i        (operands),
    .alu_i             (alu_res),
    .div_i             (div_res),
    .cmp_i             (cmp_flags),
    .result_o          (result_o),
    .cmp_o             (cmp_o),
    .decouple_status_o (decouple_status_o)
  );

endmodule

// File: verification/dpr_checker.sv
`timescale 1ns/1ps

module dpr_checker (
  input logic                clk,
  input logic                rst_n_i,
  input logic                decouple_i,
  input dpr_pkg::word_t      result_i,
  input dpr_pkg::cmp_flags_t cmp_flags_i,
  input logic                status_i
);

  // A reset edge clears every output register
  reset_clears_outputs: assert property (@(posedge clk)
    !rst_n_i |=> (result_i == '0 && cmp_flags_i == '0 && !status_i))
    else $error("outputs not cleared after a reset edge");

  // Status is the decouple request delayed by one edge
  status_follows_request: assert property (@(posedge clk)
    rst_n_i |=> (status_i == $past(decouple_i)))
    else $error("decouple status does not match the previous request");

  // Decoupled edge leaves result and flags untouched
  hold_while_decoupled: assert property (@(posedge clk)
    (rst_n_i && decouple_i) |=> ($stable(result_i) && $stable(cmp_flags_i)))
    else $error("outputs changed across a decoupled edge");

  // Exactly one of lt, gt, eq after a normal update
  flags_one_hot: assert property (@(posedge clk)
    (rst_n_i && !decouple_i) |=> $onehot(cmp_flags_i))
    else $error("comparator flags are not one-hot");

endmodule

bind result_stage dpr_checker u_checker (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .decouple_i  (decouple_i),
  .result_i    (result_o),
  .cmp_flags_i (cmp_o),
  .status_i    (decouple_status_o)
);

// File: verification/tb_dpr_top.sv
`timescale 1ns/1ps

module tb_dpr_top;

  // Limit well above the roughly 300 cycles that all tests take
  localparam int MAX_CYCLES = 2000;

  logic                clk = 1'b0;
  logic                rst_n_i;
  dpr_pkg::word_t      a_i;
  dpr_pkg::word_t      b_i;
  logic [4:0]          op_sel_i;
  logic                mux_sel_i;
  logic                decouple_i;
  dpr_pkg::word_t      result_o;
  dpr_pkg::cmp_flags_t cmp_o;
  logic                decouple_status_o;

  int seed;
  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;

  dpr_top dut0 (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .a_i               (a_i),
    .b_i               (b_i),
    .op_sel_i          (op_sel_i),
    .mux_sel_i         (mux_sel_i),
    .decouple_i        (decouple_i),
    .result_o          (result_o),
    .cmp_o             (cmp_o),
    .decouple_status_o (decouple_status_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic dpr_pkg::word_t rand_word();
    return dpr_pkg::word_t'($random(seed));
  endfunction

  // Expected result of each operation in unsigned modulo 256 arithmetic
  function automatic dpr_pkg::word_t model_result(input dpr_pkg::word_t a,
      input dpr_pkg::word_t b, input logic [4:0] op, input logic msel,
      input dpr_pkg::word_t prev_a);
    dpr_pkg::word_t r;
    case (op)
      dpr_pkg::OP_ADD: r = a + b;
      dpr_pkg::OP_SUB: r = a - b;
      dpr_pkg::OP_INC: r = a + 8'd1;
      dpr_pkg::OP_DEC: r = a - 8'd1;
      dpr_pkg::OP_MUL: r = a * b;
      dpr_pkg::OP_DIV: r = (b == 8'd0) ? 8'hFF : a / b;
      dpr_pkg::OP_MOD: r = (b == 8'd0) ? a : a % b;
      dpr_pkg::OP_SHL: r = (b > 8'd7) ? 8'd0 : a << b;
      dpr_pkg::OP_SHR: r = (b > 8'd7) ? 8'd0 : a >> b;
      dpr_pkg::OP_MUX: r = msel ? b : a;
      dpr_pkg::OP_REG: r = prev_a;
      default:         r = 8'd0;
    endcase
    return r;
  endfunction

  function automatic dpr_pkg::cmp_flags_t model_flags(input dpr_pkg::word_t a,
      input dpr_pkg::word_t b);
    return '{lt: (a < b), gt: (a > b), eq: (a == b)};
  endfunction

  task automatic check_word(input string name, input dpr_pkg::word_t exp,
      input dpr_pkg::word_t act);
    if (exp !== act) begin
      $display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flags(input dpr_pkg::cmp_flags_t exp, input dpr_pkg::cmp_flags_t act);
    if (exp !== act) begin
      $display("[FAIL] %0d ns: cmp_o expected %b, got %b", $time, exp, act);
      error_count++;
    end
  endtask

  task automatic check_status(input logic exp);
    if (exp !== decouple_status_o) begin
      $display("[FAIL] %0d ns: decouple_status_o expected %b, got %b",
               $time, exp, decouple_status_o);
      error_count++;
    end
  endtask

  // Called 1 ns after an edge, so inputs change away from the clock
  task automatic apply(input dpr_pkg::word_t a, input dpr_pkg::word_t b,
      input logic [4:0] op, input logic msel, input logic dec);
    a_i        = a;
    b_i        = b;
    op_sel_i   = op;
    mux_sel_i  = msel;
    decouple_i = dec;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // One normal cycle where a_i still holds the a of the previous edge
  task automatic run_op(input dpr_pkg::word_t a, input dpr_pkg::word_t b,
      input logic [4:0] op, input logic msel);
    dpr_pkg::word_t      exp_res;
    dpr_pkg::cmp_flags_t exp_cmp;
    exp_res = model_result(a, b, op, msel, a_i);
    exp_cmp = model_flags(a, b);
    apply(a, b, op, msel, 1'b0);
    step();
    check_word("result_o", exp_res, result_o);
    check_flags(exp_cmp, cmp_o);
    check_status(1'b0);
  endtask

  task automatic finish_test(input string name, input int errors_at_start);
    if (error_count == errors_at_start) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d mismatches", name, error_count - errors_at_start);
    end
  endtask

  task automatic test_reset();
    int start;
    start = error_count;
    repeat (2) @(posedge clk);
    #1;
    check_word("result_o", 8'd0, result_o);
    check_flags('0, cmp_o);
    check_status(1'b0);
    rst_n_i    = 1'b1;
    decouple_i = 1'b0;
    finish_test("reset", start);
  endtask

  task automatic test_arith();
    int start;
    dpr_pkg::word_t a;
    dpr_pkg::word_t b;
    start = error_count;
    for (int i = 0; i < 40; i++) begin
      a = rand_word();
      b = rand_word();
      run_op(a, b, dpr_pkg::OP_ADD, 1'b0);
      run_op(a, b, dpr_pkg::OP_SUB, 1'b0);
      run_op(a, b, dpr_pkg::OP_INC, 1'b0);
      run_op(a, b, dpr_pkg::OP_DEC, 1'b0);
      run_op(a, b, dpr_pkg::OP_MUL, 1'b0);
    end
    // Wrap at both ends of the range
    run_op(8'hFF, 8'h01, dpr_pkg::OP_INC, 1'b0);
    run_op(8'h00, 8'h01, dpr_pkg::OP_DEC, 1'b0);
    finish_test("arithmetic", start);
  endtask

  task automatic test_division();
    int start;
    dpr_pkg::word_t a;
    dpr_pkg::word_t b;
    start = error_count;
    for (int i = 0; i < 20; i++) begin
      a = rand_word();
      b = rand_word() >> (i % 8);
      run_op(a, b, dpr_pkg::OP_DIV, 1'b0);
      run_op(a, b, dpr_pkg::OP_MOD, 1'b0);
    end
    // Divide by zero
    run_op(8'hA7, 8'h00, dpr_pkg::OP_DIV, 1'b0);
    run_op(8'hA7, 8'h00, dpr_pkg::OP_MOD, 1'b0);
    run_op(8'h00, 8'h00, dpr_pkg::OP_DIV, 1'b0);
    finish_test("division", start);
  endtask

  task automatic test_shift_mux();
    int start;
    dpr_pkg::word_t amounts [7] = '{8'd0, 8'd1, 8'd3, 8'd7, 8'd8, 8'd9, 8'd200};
    start = error_count;
    foreach (amounts[i]) begin
      run_op(rand_word(), amounts[i], dpr_pkg::OP_SHL, 1'b0);
      run_op(rand_word(), amounts[i], dpr_pkg::OP_SHR, 1'b0);
    end
    run_op(8'h3C, 8'hC3, dpr_pkg::OP_MUX, 1'b0);
    run_op(8'h3C, 8'hC3, dpr_pkg::OP_MUX, 1'b1);
    run_op(rand_word(), rand_word(), dpr_pkg::OP_MUX, 1'b1);
    run_op(8'h5A, 8'h11, 5'd11, 1'b0);
    run_op(8'h5A, 8'h11, 5'd31, 1'b1);
    finish_test("shift_mux_undefined", start);
  endtask

  task automatic test_reg_cmp();
    int start;
    dpr_pkg::word_t a;
    start = error_count;
    for (int i = 0; i < 10; i++) begin
      run_op(rand_word(), rand_word(), dpr_pkg::OP_REG, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      a = rand_word();
      run_op(a, a, dpr_pkg::OP_SUB, 1'b0);
      run_op(a, rand_word(), dpr_pkg::OP_ADD, 1'b0);
    end
    run_op(8'h00, 8'hFF, dpr_pkg::OP_ADD, 1'b0);
    run_op(8'hFF, 8'h00, dpr_pkg::OP_ADD, 1'b0);
    finish_test("reg_compare", start);
  endtask

  task automatic test_decouple();
    int start;
    dpr_pkg::word_t      held_res;
    dpr_pkg::cmp_flags_t held_cmp;
    dpr_pkg::word_t      stored_a;
    start = error_count;
    held_res = model_result(8'h21, 8'h13, dpr_pkg::OP_SUB, 1'b0, 8'h00);
    held_cmp = model_flags(8'h21, 8'h13);
    run_op(8'h21, 8'h13, dpr_pkg::OP_SUB, 1'b0);
    for (int i = 0; i < 4; i++) begin
      apply(rand_word(), rand_word(), (i % 2 == 0) ? 5'(dpr_pkg::OP_MUL) : 5'(dpr_pkg::OP_ADD),
            1'b0, 1'b1);
      step();
      check_word("result_o", held_res, result_o);
      check_flags(held_cmp, cmp_o);
      check_status(1'b1);
    end
    // REG store kept sampling a while decoupled
    stored_a = a_i;
    apply(8'h77, 8'h80, dpr_pkg::OP_REG, 1'b0, 1'b0);
    step();
    check_word("result_o", stored_a, result_o);
    check_flags(model_flags(8'h77, 8'h80), cmp_o);
    check_status(1'b0);
    run_op(8'h77, 8'h80, dpr_pkg::OP_ADD, 1'b0);
    finish_test("decouple", start);
  endtask

  initial begin
    seed       = 84;
    rst_n_i    = 1'b0;
    a_i        = 8'h55;
    b_i        = 8'h0A;
    op_sel_i   = dpr_pkg::OP_ADD;
    mux_sel_i  = 1'b0;
    decouple_i = 1'b1;

    test_reset();
    test_arith();
    test_division();
    test_shift_mux();
    test_reg_cmp();
    test_decouple();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/dpr_pkg.sv
hdl/arith_unit.sv
hdl/divide_unit.sv
hdl/result_stage.sv
hdl/dpr_top.sv
verification/dpr_checker.sv
verification/tb_dpr_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_dpr_top -o sim_tb

sim_out=$(./obj_dir/sim_tb) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
